// File: bench/core_trace.txt
// inst rdata pc rd_en wr_en address byte_en wdata mask, one cycle per line, hex
// mask bits: 01 pc, 02 rd_en, 04 wr_en, 08 address, 10 byte_en, 20 wdata
// Fetch, ALU results stored with SW
12300093 deadbeef 00000000 0 0 00000000 0 00000000 07
80000137 deadbeef 00000004 0 0 00000000 0 00000000 07
00001197 deadbeef 00000008 0 0 00000000 0 00000000 07
10000513 deadbeef 0000000c 0 0 00000000 0 00000000 07
00352023 deadbeef 00000010 0 1 00000100 f 00001008 3f
00252223 deadbeef 00000014 0 1 00000104 f 80000000 3f
ffb00213 deadbeef 00000018 0 0 00000000 0 00000000 07
004082b3 deadbeef 0000001c 0 0 00000000 0 00000000 07
00552423 deadbeef 00000020 0 1 00000108 f 0000011e 3f
40120333 deadbeef 00000024 0 0 00000000 0 00000000 07
00652623 deadbeef 00000028 0 1 0000010c f fffffed8 3f
00409393 deadbeef 0000002c 0 0 00000000 0 00000000 07
40125413 deadbeef 00000030 0 0 00000000 0 00000000 07
001254b3 deadbeef 00000034 0 0 00000000 0 00000000 07
00752823 deadbeef 00000038 0 1 00000110 f 00001230 3f
00852a23 deadbeef 0000003c 0 1 00000114 f fffffffd 3f
00952c23 deadbeef 00000040 0 1 00000118 f 1fffffff 3f
001225b3 deadbeef 00000044 0 0 00000000 0 00000000 07
00123633 deadbeef 00000048 0 0 00000000 0 00000000 07
00b52e23 deadbeef 0000004c 0 1 0000011c f 00000001 3f
02c52023 deadbeef 00000050 0 1 00000120 f 00000000 3f
0f00c693 deadbeef 00000054 0 0 00000000 0 00000000 07
00d0e733 deadbeef 00000058 0 0 00000000 0 00000000 07
0f577793 deadbeef 0000005c 0 0 00000000 0 00000000 07
02d52223 deadbeef 00000060 0 1 00000124 f 000001d3 3f
02e52423 deadbeef 00000064 0 1 00000128 f 000001f3 3f
02f52623 deadbeef 00000068 0 1 0000012c f 000000f1 3f
// Byte and halfword store lanes
a1b2c837 deadbeef 0000006c 0 0 00000000 0 00000000 07
3d480813 deadbeef 00000070 0 0 00000000 0 00000000 07
01050023 deadbeef 00000074 0 1 00000100 1 d4d4d4d4 3f
010500a3 deadbeef 00000078 0 1 00000101 2 d4d4d4d4 3f
01050123 deadbeef 0000007c 0 1 00000102 4 d4d4d4d4 3f
010501a3 deadbeef 00000080 0 1 00000103 8 d4d4d4d4 3f
01051023 deadbeef 00000084 0 1 00000100 3 c3d4c3d4 3f
01051123 deadbeef 00000088 0 1 00000102 c c3d4c3d4 3f
// Loads, each result stored back
00050883 80f17f92 0000008c 1 0 00000100 1 00000000 1f
01152023 deadbeef 00000090 0 1 00000100 f ffffff92 3f
00254903 80f17f92 00000094 1 0 00000102 4 00000000 1f
01252223 deadbeef 00000098 0 1 00000104 f 000000f1 3f
00150983 80f17f92 0000009c 1 0 00000101 2 00000000 1f
01352423 deadbeef 000000a0 0 1 00000108 f 0000007f 3f
00251a03 80f17f92 000000a4 1 0 00000102 c 00000000 1f
01452623 deadbeef 000000a8 0 1 0000010c f ffff80f1 3f
00255a83 80f17f92 000000ac 1 0 00000102 c 00000000 1f
01552823 deadbeef 000000b0 0 1 00000110 f 000080f1 3f
00051b03 80f17f92 000000b4 1 0 00000100 3 00000000 1f
00052b83 80f17f92 000000b8 1 0 00000100 f 00000000 1f
01652a23 deadbeef 000000bc 0 1 00000114 f 00007f92 3f
01752c23 deadbeef 000000c0 0 1 00000118 f 80f17f92 3f
// Branches taken and not taken, then JAL, JALR and link values
00108463 deadbeef 000000c4 0 0 00000000 0 00000000 07
00109463 deadbeef 000000cc 0 0 00000000 0 00000000 07
00409463 deadbeef 000000d0 0 0 00000000 0 00000000 07
00124463 deadbeef 000000d8 0 0 00000000 0 00000000 07
0040c463 deadbeef 000000e0 0 0 00000000 0 00000000 07
0040d463 deadbeef 000000e4 0 0 00000000 0 00000000 07
00125463 deadbeef 000000ec 0 0 00000000 0 00000000 07
00126463 deadbeef 000000f0 0 0 00000000 0 00000000 07
fe40ece3 deadbeef 000000f4 0 0 00000000 0 00000000 07
00127463 deadbeef 000000ec 0 0 00000000 0 00000000 07
0040f463 deadbeef 000000f4 0 0 00000000 0 00000000 07
00c58463 deadbeef 000000f8 0 0 00000000 0 00000000 07
02000c6f deadbeef 000000fc 0 0 00000000 0 00000000 07
00118ce7 deadbeef 0000011c 0 0 00000000 0 00000000 07
01852023 deadbeef 00001008 0 1 00000100 f 00000100 3f
01952223 deadbeef 0000100c 0 1 00000104 f 00000120 3f
// x0 stays zero, unknown opcode runs as a no-op
05508013 deadbeef 00001010 0 0 00000000 0 00000000 07
00052423 deadbeef 00001014 0 1 00000108 f 00000000 3f
00052003 12345678 00001018 1 0 00000100 f 00000000 1f
00052623 deadbeef 0000101c 0 1 0000010c f 00000000 3f
0000000b deadbeef 00001020 0 0 00000000 0 00000000 07
00000013 deadbeef 00001024 0 0 00000000 0 00000000 07

// File: compile.f
source/rv_pkg.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_control.sv
source/rv_datapath.sv
source/rv_dmem_if.sv
source/rv_core.sv
bench/rv_core_tb.sv

// File: Makefile
# Verilator build and run for the RV32I core testbench

VERILATOR  ?= verilator
TOP        ?= rv_core_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing
LINT_FLAGS ?= -Wall
PASS_MSG   ?= All tests passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/rv_core_tb.sv
/*
 * Testbench for the single-cycle RV32I core
 * Per-cycle instruction and read data come from a trace, pc and bus are checked
 */

`timescale 1ns/10ps

module rv_core_tb;

  localparam logic [31:0] reset_pc     = 32'h0000_0000;
  localparam int          reset_cycles = 16;
  localparam int          fields       = 9;
  localparam int          max_lines    = 4096 / fields;
  localparam string       trace_path   = "bench/core_trace.txt";

  logic        clock;
  logic        rst;
  logic [31:0] inst;
  logic [31:0] bus_read_data;
  logic [31:0] pc;
  logic [31:0] bus_address;
  logic [31:0] bus_write_data;
  logic [3:0]  bus_byte_enable;
  logic        bus_read_enable;
  logic        bus_write_enable;

  logic [31:0] trace_mem [4096];
  int          n_lines;
  int          checks;
  int          errors;
  int          cycles = 0;
  int          cycle_limit = reset_cycles + 20;

  rv_core #(
    .reset_pc (reset_pc)
  ) dut_i (
    .clock            (clock),
    .rst              (rst),
    .inst             (inst),
    .bus_read_data    (bus_read_data),
    .pc               (pc),
    .bus_address      (bus_address),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
  );

  always #4 clock = ~clock;

  // Run limit
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not end within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  function automatic logic [31:0] field(input int line, input int column);
    logic [11:0] index;
    index = 12'(line * fields + column);
    return trace_mem[index];
  endfunction

  task automatic check_reset_state();
    compare("pc", reset_pc, pc);
    compare("bus_read_enable", 32'd0, {31'd0, bus_read_enable});
    compare("bus_write_enable", 32'd0, {31'd0, bus_write_enable});
  endtask

  // Mask bits pick the fields that matter on this line
  task automatic check_line(input int line);
    logic [31:0] mask;
    mask = field(line, 8);
    if (mask[0]) compare("pc", field(line, 2), pc);
    if (mask[1]) compare("bus_read_enable", field(line, 3), {31'd0, bus_read_enable});
    if (mask[2]) compare("bus_write_enable", field(line, 4), {31'd0, bus_write_enable});
    if (mask[3]) compare("bus_address", field(line, 5), bus_address);
    if (mask[4]) compare("bus_byte_enable", field(line, 6), {28'd0, bus_byte_enable});
    if (mask[5]) compare("bus_write_data", field(line, 7), bus_write_data);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  initial begin
    int fd;
    clock         = 1'b0;
    rst           = 1'b1;
    inst          = 32'h0000_0013;
    bus_read_data = '0;
    checks        = 0;
    errors        = 0;
    n_lines       = 0;

    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      $display("The trace file %s could not be opened", trace_path);
      errors++;
    end else begin
      $fclose(fd);
      for (int i = 0; i < 4096; i++) begin
        trace_mem[12'(i)] = '0;
      end
      $readmemh(trace_path, trace_mem);
      // A line ends the trace when its mask is zero
      while (n_lines < max_lines && field(n_lines, 8) != 0) begin
        n_lines++;
      end
      if (n_lines == 0) begin
        $display("The trace file %s holds no cycles", trace_path);
        errors++;
      end
      cycle_limit = n_lines + reset_cycles + 20;
    end

    // Loads and stores offered during reset must not reach the bus
    for (int c = 0; c < reset_cycles; c++) begin
      @(posedge clock);
      #1;
      inst = c[0] ? 32'h0000_2083 : 32'h0010_2023;
      #6;
      check_reset_state();
    end

    for (int line = 0; line < n_lines; line++) begin
      @(posedge clock);
      #1;
      rst           = 1'b0;
      inst          = field(line, 0);
      bus_read_data = field(line, 1);
      #6;
      check_line(line);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: source/rv_core.sv
/*
 * Single-cycle RV32I core top level
 * Control, datapath and data bus steering
 */

`timescale 1ns/10ps

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clock,
  input  logic                    rst,
  input  logic [rv_pkg::xlen-1:0] inst,
  input  logic [rv_pkg::xlen-1:0] bus_read_data,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] bus_address,
  output logic [rv_pkg::xlen-1:0] bus_write_data,
  output logic [3:0]              bus_byte_enable,
  output logic                    bus_read_enable,
  output logic                    bus_write_enable
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic                    alu_zero;
  rv_pkg::alu_fn_e         alu_fn;
  rv_pkg::alu_a_sel_e      a_sel;
  rv_pkg::alu_b_sel_e      b_sel;
  rv_pkg::wb_sel_e         wb_sel;
  rv_pkg::next_pc_e        next_sel;
  logic                    reg_we;
  logic                    pc_we;
  rv_pkg::data_fmt_e       data_fmt;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] load_data;

  rv_control control (
    .rst       (rst),
    .opcode    (opcode),
    .funct3    (funct3),
    .funct7    (funct7),
    .alu_zero  (alu_zero),
    .alu_fn    (alu_fn),
    .a_sel     (a_sel),
    .b_sel     (b_sel),
    .reg_we    (reg_we),
    .wb_sel    (wb_sel),
    .next_sel  (next_sel),
    .pc_we     (pc_we),
    .mem_read  (bus_read_enable),
    .mem_write (bus_write_enable)
  );

  rv_datapath #(
    .reset_pc (reset_pc)
  ) datapath (
    .clock      (clock),
    .rst        (rst),
    .inst       (inst),
    .alu_fn     (alu_fn),
    .a_sel      (a_sel),
    .b_sel      (b_sel),
    .wb_sel     (wb_sel),
    .next_sel   (next_sel),
    .reg_we     (reg_we),
    .pc_we      (pc_we),
    .load_data  (load_data),
    .pc         (pc),
    .opcode     (opcode),
    .funct3     (funct3),
    .funct7     (funct7),
    .data_fmt   (data_fmt),
    .alu_result (bus_address),
    .alu_zero   (alu_zero),
    .rs2_data   (rs2_data)
  );

  // ALU result doubles as the data bus address
  rv_dmem_if dmem (
    .address         (bus_address),
    .write_data      (rs2_data),
    .data_fmt        (data_fmt),
    .bus_read_data   (bus_read_data),
    .bus_write_data  (bus_write_data),
    .bus_byte_enable (bus_byte_enable),
    .load_data       (load_data)
  );

endmodule

// File: source/rv_dmem_if.sv
/*
 * Data bus lane steering: byte enables, store data replication and
 * load lane extraction with sign or zero extension
 */

`timescale 1ns/10ps

module rv_dmem_if (
  input  logic [rv_pkg::xlen-1:0] address,
  input  logic [rv_pkg::xlen-1:0] write_data,
  input  rv_pkg::data_fmt_e       data_fmt,
  input  logic [rv_pkg::xlen-1:0] bus_read_data,
  output logic [rv_pkg::xlen-1:0] bus_write_data,
  output logic [3:0]              bus_byte_enable,
  output logic [rv_pkg::xlen-1:0] load_data
);

  logic [rv_pkg::xlen-1:0] lane_data;

  // Addressed byte moved down to bit 0
  assign lane_data = bus_read_data >> {address[1:0], 3'b000};

  always_comb begin
    case (data_fmt)
      rv_pkg::fmt_byte, rv_pkg::fmt_byte_u: begin
        bus_byte_enable = 4'b0001 << address[1:0];
        bus_write_data  = {4{write_data[7:0]}};
      end
      rv_pkg::fmt_half, rv_pkg::fmt_half_u: begin
        bus_byte_enable = address[1] ? 4'b1100 : 4'b0011;
        bus_write_data  = {2{write_data[15:0]}};
      end
      default: begin
        bus_byte_enable = 4'b1111;
        bus_write_data  = write_data;
      end
    endcase
  end

  always_comb begin
    case (data_fmt)
      rv_pkg::fmt_byte:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      rv_pkg::fmt_byte_u: load_data = {24'd0, lane_data[7:0]};
      rv_pkg::fmt_half:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      rv_pkg::fmt_half_u: load_data = {16'd0, lane_data[15:0]};
      default:            load_data = bus_read_data;
    endcase
  end

endmodule

// File: source/rv_datapath.sv
/*
 * Single-cycle datapath: pc register, instruction fields, immediates,
 * operand and writeback muxes and next-pc logic around regfile and ALU
 */

`timescale 1ns/10ps

module rv_datapath #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clock,
  input  logic                    rst,
  input  logic [rv_pkg::xlen-1:0] inst,
  input  rv_pkg::alu_fn_e         alu_fn,
  input  rv_pkg::alu_a_sel_e      a_sel,
  input  rv_pkg::alu_b_sel_e      b_sel,
  input  rv_pkg::wb_sel_e         wb_sel,
  input  rv_pkg::next_pc_e        next_sel,
  input  logic                    reg_we,
  input  logic                    pc_we,
  input  logic [rv_pkg::xlen-1:0] load_data,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [6:0]              opcode,
  output logic [2:0]              funct3,
  output logic [6:0]              funct7,
  output rv_pkg::data_fmt_e       data_fmt,
  output logic [rv_pkg::xlen-1:0] alu_result,
  output logic                    alu_zero,
  output logic [rv_pkg::xlen-1:0] rs2_data
);

  logic [rv_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic [rv_pkg::xlen-1:0] rs1_data, alu_a, alu_b, wb_data;
  logic [rv_pkg::xlen-1:0] pc_plus4, next_pc;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign data_fmt = rv_pkg::data_fmt_e'(inst[14:12]);

  // --------------------------------------------------------------------------
  // Immediates
  // --------------------------------------------------------------------------

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'd0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      rv_pkg::opc_store:                  imm = imm_s;
      rv_pkg::opc_branch:                 imm = imm_b;
      rv_pkg::opc_lui, rv_pkg::opc_auipc: imm = imm_u;
      rv_pkg::opc_jal:                    imm = imm_j;
      default:                            imm = imm_i;
    endcase
  end

  // --------------------------------------------------------------------------
  // Register file and ALU
  // --------------------------------------------------------------------------

  rv_regfile regfile (
    .clock    (clock),
    .rs1_addr (inst[19:15]),
    .rs2_addr (inst[24:20]),
    .rd_addr  (inst[11:7]),
    .rd_data  (wb_data),
    .we       (reg_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = (a_sel == rv_pkg::a_pc) ? pc : rs1_data;
  assign alu_b = (b_sel == rv_pkg::b_imm) ? imm : rs2_data;

  rv_alu alu (
    .fn     (alu_fn),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

  always_comb begin
    case (wb_sel)
      rv_pkg::wb_mem: wb_data = load_data;
      rv_pkg::wb_pc4: wb_data = pc_plus4;
      rv_pkg::wb_imm: wb_data = imm;
      default:        wb_data = alu_result;
    endcase
  end

  // --------------------------------------------------------------------------
  // Program counter
  // --------------------------------------------------------------------------

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (next_sel)
      rv_pkg::pc_branch: next_pc = pc + imm_b;
      rv_pkg::pc_jal:    next_pc = pc + imm_j;
      rv_pkg::pc_jalr:   next_pc = {alu_result[31:1], 1'b0};
      default:           next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (pc_we) begin
      pc <= next_pc;
    end
  end

endmodule

// File: source/rv_control.sv
/*
 * Control unit: opcode and funct decode into ALU function, operand and
 * writeback selects, next-pc select and register/memory strobes
 */

`timescale 1ns/10ps

module rv_control (
  input  logic                 rst,
  input  logic [6:0]           opcode,
  input  logic [2:0]           funct3,
  input  logic [6:0]           funct7,
  input  logic                 alu_zero,
  output rv_pkg::alu_fn_e      alu_fn,
  output rv_pkg::alu_a_sel_e   a_sel,
  output rv_pkg::alu_b_sel_e   b_sel,
  output logic                 reg_we,
  output rv_pkg::wb_sel_e      wb_sel,
  output rv_pkg::next_pc_e     next_sel,
  output logic                 pc_we,
  output logic                 mem_read,
  output logic                 mem_write
);

  rv_pkg::alu_fn_e arith_fn;
  rv_pkg::alu_fn_e branch_fn;

  // Register and immediate ALU ops share funct3
  always_comb begin
    case (funct3)
      3'b000:  arith_fn = (opcode == rv_pkg::opc_op && funct7[5]) ? rv_pkg::alu_sub
                                                                  : rv_pkg::alu_add;
      3'b001:  arith_fn = rv_pkg::alu_sll;
      3'b010:  arith_fn = rv_pkg::alu_slt;
      3'b011:  arith_fn = rv_pkg::alu_sltu;
      3'b100:  arith_fn = rv_pkg::alu_xor;
      3'b101:  arith_fn = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  arith_fn = rv_pkg::alu_or;
      default: arith_fn = rv_pkg::alu_and;
    endcase
  end

  // Compare result is 1 when the branch is taken
  always_comb begin
    case (funct3)
      3'b001:  branch_fn = rv_pkg::alu_sne;
      3'b100:  branch_fn = rv_pkg::alu_slt;
      3'b101:  branch_fn = rv_pkg::alu_sge;
      3'b110:  branch_fn = rv_pkg::alu_sltu;
      3'b111:  branch_fn = rv_pkg::alu_sgeu;
      default: branch_fn = rv_pkg::alu_seq;
    endcase
  end

  always_comb begin
    alu_fn    = rv_pkg::alu_add;
    a_sel     = rv_pkg::a_rs1;
    b_sel     = rv_pkg::b_imm;
    reg_we    = 1'b0;
    wb_sel    = rv_pkg::wb_alu;
    next_sel  = rv_pkg::pc_plus4;
    pc_we     = 1'b1;
    mem_read  = 1'b0;
    mem_write = 1'b0;

    case (opcode)
      rv_pkg::opc_load: begin
        reg_we   = 1'b1;
        wb_sel   = rv_pkg::wb_mem;
        mem_read = 1'b1;
      end
      rv_pkg::opc_store: mem_write = 1'b1;
      rv_pkg::opc_op_imm: begin
        alu_fn = arith_fn;
        reg_we = 1'b1;
      end
      rv_pkg::opc_op: begin
        alu_fn = arith_fn;
        b_sel  = rv_pkg::b_rs2;
        reg_we = 1'b1;
      end
      rv_pkg::opc_lui: begin
        reg_we = 1'b1;
        wb_sel = rv_pkg::wb_imm;
      end
      rv_pkg::opc_auipc: begin
        a_sel  = rv_pkg::a_pc;
        reg_we = 1'b1;
      end
      rv_pkg::opc_jal: begin
        a_sel    = rv_pkg::a_pc;
        reg_we   = 1'b1;
        wb_sel   = rv_pkg::wb_pc4;
        next_sel = rv_pkg::pc_jal;
      end
      rv_pkg::opc_jalr: begin
        reg_we   = 1'b1;
        wb_sel   = rv_pkg::wb_pc4;
        next_sel = rv_pkg::pc_jalr;
      end
      rv_pkg::opc_branch: begin
        alu_fn   = branch_fn;
        b_sel    = rv_pkg::b_rs2;
        next_sel = alu_zero ? rv_pkg::pc_plus4 : rv_pkg::pc_branch;
      end
      default: ;
    endcase

    // No side effects while in reset
    if (rst) begin
      reg_we    = 1'b0;
      pc_we     = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
    end
  end

endmodule

// File: source/rv_regfile.sv
/*
 * Integer register file, 32 x 32 bits
 * Two asynchronous read ports, one synchronous write port, x0 reads zero
 */

`timescale 1ns/10ps

module rv_regfile (
  input  logic                    clock,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  input  logic [4:0]              rd_addr,
  input  logic [rv_pkg::xlen-1:0] rd_data,
  input  logic                    we,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);

  logic [rv_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (we && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 is never written, so force it on the read side
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: source/rv_alu.sv
/*
 * Combinational RV32I ALU with compare functions for branches
 * and an all-zero result flag
 */

`timescale 1ns/10ps

module rv_alu (
  input  rv_pkg::alu_fn_e         fn,
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (fn)
      rv_pkg::alu_add:  result = a + b;
      rv_pkg::alu_sub:  result = a - b;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu: result = {31'd0, a < b};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      rv_pkg::alu_seq:  result = {31'd0, a == b};
      rv_pkg::alu_sne:  result = {31'd0, a != b};
      rv_pkg::alu_sge:  result = {31'd0, $signed(a) >= $signed(b)};
      rv_pkg::alu_sgeu: result = {31'd0, a >= b};
      default:          result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: source/rv_pkg.sv
/*
 * Shared RV32I encodings: major opcodes, ALU functions, operand and
 * writeback selects, next-pc selects and load/store data formats
 */

package rv_pkg;

  localparam int xlen = 32;

  // --------------------------------------------------------------------------
  // Instruction encodings
  // --------------------------------------------------------------------------

  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011
  } opcode_e;

  // Load and store size, same bits as funct3
  typedef enum logic [2:0] {
    fmt_byte   = 3'b000,
    fmt_half   = 3'b001,
    fmt_word   = 3'b010,
    fmt_byte_u = 3'b100,
    fmt_half_u = 3'b101
  } data_fmt_e;

  // --------------------------------------------------------------------------
  // Datapath control
  // --------------------------------------------------------------------------

  // Compare codes give 0 or 1
  typedef enum logic [4:0] {
    alu_add  = 5'd0,
    alu_sub  = 5'd1,
    alu_sll  = 5'd2,
    alu_slt  = 5'd3,
    alu_sltu = 5'd4,
    alu_xor  = 5'd5,
    alu_srl  = 5'd6,
    alu_sra  = 5'd7,
    alu_or   = 5'd8,
    alu_and  = 5'd9,
    alu_seq  = 5'd10,
    alu_sne  = 5'd11,
    alu_sge  = 5'd12,
    alu_sgeu = 5'd13
  } alu_fn_e;

  typedef enum logic {
    a_rs1 = 1'b0,
    a_pc  = 1'b1
  } alu_a_sel_e;

  typedef enum logic {
    b_rs2 = 1'b0,
    b_imm = 1'b1
  } alu_b_sel_e;

  typedef enum logic [2:0] {
    wb_alu = 3'd0,
    wb_mem = 3'd1,
    wb_pc4 = 3'd2,
    wb_imm = 3'd3
  } wb_sel_e;

  typedef enum logic [1:0] {
    pc_plus4  = 2'd0,
    pc_branch = 2'd1,
    pc_jal    = 2'd2,
    pc_jalr   = 2'd3
  } next_pc_e;

endpackage
